//--- bench/masku_tb_tasks.svh
`ifndef MASKU_TB_TASKS_SVH
`define MASKU_TB_TASKS_SVH

////////////////////////////////////////
// Reference model
////////////////////////////////////////

// Merge word with the enabled-bit count of b and the mask beat total
task automatic compute_expected();
  logic        enable;
  int unsigned elems;
  exp_pop = '0;
  for (int i = 0; i < VrfW; i++) begin
    enable = (i < cur_vl) && (cur_vm || cur_m[i]);
    exp_word[i] = enable ? cur_a[i] : cur_b[i];
    if (enable && cur_b[i]) exp_pop++;
  end
  // Elements per beat shrink as the element grows
  elems = (NrLanes * 8) >> cur_sew;
  exp_beats = (cur_vl + elems - 1) / elems;
endtask

// Byte strobes of one lane in mask beat k
function automatic logic [StrbW-1:0] expect_strobe(int unsigned beat, int unsigned lane);
  int unsigned      slot_bytes;
  int unsigned      elem;
  logic [StrbW-1:0] strb;
  slot_bytes = 1 << cur_sew;
  for (int b = 0; b < StrbW; b++) begin
    elem = beat * ((NrLanes * 8) / slot_bytes) + NrLanes * (b / slot_bytes) + lane;
    strb[b] = (elem < cur_vl) ? cur_m[elem] : 1'b0;
  end
  return strb;
endfunction

// A lane takes part in a beat while its first element is below vl
function automatic logic lane_active(int unsigned beat, int unsigned lane);
  return (beat * ((NrLanes * 8) >> cur_sew) + lane) < cur_vl;
endfunction

////////////////////////////////////////
// Drivers
////////////////////////////////////////

task automatic random_word(output logic [VrfW-1:0] word);
  word = {$random(seed), $random(seed), $random(seed), $random(seed)};
endtask

task automatic flag_mismatch(string msg);
  errors++;
  $display("mismatch at %0t: %s", $time, msg);
endtask

// Next drive point with random grants and readies when throttled
task automatic advance_cycle();
  @(posedge clk_i);
  #2;
  result_gnt_i = throttle ? NrLanes'($random(seed)) : '1;
  mask_ready_i = throttle ? NrLanes'($random(seed)) : '1;
endtask

task automatic drop_operands();
  operand_a_valid_i = '0;
  operand_b_valid_i = '0;
  operand_m_valid_i = '0;
endtask

// One instruction from request to done
task automatic run_insn(masku_op_e op, logic vm, sew_e sew, logic [VlW-1:0] vl);
  logic seen_ready;
  logic seen_done;
  cur_op  = op;
  cur_vm  = vm;
  cur_sew = sew;
  cur_vl  = vl;
  cur_id  = cur_id + 1'b1;
  cur_vd  = VdW'($random(seed));
  random_word(cur_a);
  random_word(cur_b);
  random_word(cur_m);
  compute_expected();
  beats_seen   = 0;
  results_seen = 0;
  req_op_i    = op;
  req_vm_i    = vm;
  req_sew_i   = sew;
  req_vl_i    = vl;
  req_id_i    = cur_id;
  req_vd_i    = cur_vd;
  req_valid_i = 1'b1;
  do begin
    @(negedge clk_i);
    seen_ready = req_ready_o;
    advance_cycle();
  end while (!seen_ready);
  req_valid_i = 1'b0;
  operand_a_i = cur_a;
  operand_b_i = cur_b;
  operand_m_i = cur_m;
  operand_a_valid_i = {NrLanes{op != MASKU_OP_MASK}};
  operand_b_valid_i = {NrLanes{op != MASKU_OP_MASK}};
  operand_m_valid_i = {NrLanes{!vm}};
  // Operands leave once consumed and the loop runs until the done pulse
  seen_ready = 1'b0;
  do begin
    @(negedge clk_i);
    seen_ready = seen_ready || (|operand_b_ready_o) || (|operand_m_ready_o);
    seen_done  = done_o;
    advance_cycle();
    if (seen_ready) drop_operands();
  end while (!seen_done);
  drop_operands();
  issued++;
endtask

`endif

//--- bench/masku_tb.sv
`default_nettype none

module masku_tb import masku_pkg::*; ();

  // Instruction budget sized for a 64-beat mask at heavy back-pressure
  localparam int unsigned NrInsns    = 40;
  localparam int unsigned BeatCycles = 8;
  localparam int unsigned MaxCycles  = NrInsns * ((VrfW / 2) * BeatCycles + 16) + 100;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          req_valid_i;
  masku_op_e                     req_op_i;
  logic                          req_vm_i;
  sew_e                          req_sew_i;
  logic [VlW-1:0]                req_vl_i;
  logic [IdW-1:0]                req_id_i;
  logic [VdW-1:0]                req_vd_i;
  logic                          req_ready_o;
  logic [NrLanes-1:0][ElenW-1:0] operand_a_i;
  logic [NrLanes-1:0]            operand_a_valid_i;
  logic [NrLanes-1:0]            operand_a_ready_o;
  logic [NrLanes-1:0][ElenW-1:0] operand_b_i;
  logic [NrLanes-1:0]            operand_b_valid_i;
  logic [NrLanes-1:0]            operand_b_ready_o;
  logic [NrLanes-1:0][ElenW-1:0] operand_m_i;
  logic [NrLanes-1:0]            operand_m_valid_i;
  logic [NrLanes-1:0]            operand_m_ready_o;
  logic [NrLanes-1:0]            result_req_o;
  logic [NrLanes-1:0][VdW-1:0]   result_addr_o;
  logic [NrLanes-1:0][IdW-1:0]   result_id_o;
  logic [NrLanes-1:0][ElenW-1:0] result_wdata_o;
  logic [NrLanes-1:0][StrbW-1:0] result_be_o;
  logic [NrLanes-1:0]            result_gnt_i;
  logic [NrLanes-1:0][StrbW-1:0] mask_o;
  logic [NrLanes-1:0]            mask_valid_o;
  logic [NrLanes-1:0]            mask_ready_i;
  logic                          done_o;
  logic [IdW-1:0]                done_id_o;
  logic [VlW-1:0]                popcount_o;

  // Instruction in flight and its expected response
  masku_op_e       cur_op = MASKU_OP_LOGIC;
  sew_e            cur_sew;
  logic            cur_vm;
  logic [VlW-1:0]  cur_vl;
  logic [IdW-1:0]  cur_id = '0;
  logic [VdW-1:0]  cur_vd;
  logic [VrfW-1:0] cur_a;
  logic [VrfW-1:0] cur_b;
  logic [VrfW-1:0] cur_m;
  logic [VrfW-1:0] exp_word;
  logic [VlW-1:0]  exp_pop;
  int unsigned     exp_beats;
  int unsigned     beats_seen;
  int unsigned     results_seen;
  int unsigned     done_count = 0;
  int unsigned     issued = 0;
  int unsigned     errors = 0;
  int unsigned     tests = 0;
  int unsigned     cycles = 0;
  int unsigned     mark;
  logic            throttle = 1'b0;
  integer          seed = 32'h89de_ac4a;
  // Lanes of the head entry already acknowledged
  logic [NrLanes-1:0] mask_acked = '0;
  logic [NrLanes-1:0] result_acked = '0;

  `include "masku_tb_tasks.svh"

  masku masku_inst (.*);

  initial begin
    clk_i = 1'b0;
  end

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Scoreboard counters
  ////////////////////////////////////////

  // An entry retires once every lane still holding it is acknowledged
  always @(posedge clk_i) begin
    if (mask_valid_o != '0 && (mask_valid_o & ~mask_ready_i) == '0) begin
      beats_seen <= beats_seen + 1;
      mask_acked <= '0;
    end else begin
      mask_acked <= mask_acked | (mask_valid_o & mask_ready_i);
    end
    if (result_req_o != '0 && (result_req_o & ~result_gnt_i) == '0) begin
      results_seen <= results_seen + 1;
      result_acked <= '0;
    end else begin
      result_acked <= result_acked | (result_req_o & result_gnt_i);
    end
    if (done_o) done_count <= done_count + 1;
  end

  // Hard stop well past the slowest legal run
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout: run did not finish within %0d cycles", MaxCycles);
      $display("Test failures found");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  assert property (@(posedge clk_i)
    !rst_ni |-> req_ready_o && result_req_o == '0 && mask_valid_o == '0 && !done_o)
    else flag_mismatch("outputs not idle in reset");

  assert property (@(posedge clk_i) disable iff (!rst_ni) done_o |-> done_id_o == cur_id)
    else flag_mismatch("done id");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o && cur_op == MASKU_OP_VCPOP |-> popcount_o == exp_pop)
    else flag_mismatch("population count");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o && cur_op == MASKU_OP_MASK |-> beats_seen == exp_beats)
    else flag_mismatch("mask beat count at done");

  // One register-file write per LOGIC and none for the others
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> results_seen == ((cur_op == MASKU_OP_LOGIC) ? 1 : 0))
    else flag_mismatch("result count at done");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cur_op == MASKU_OP_VCPOP |-> result_req_o == '0)
    else flag_mismatch("result request during VCPOP");

  // Both lanes write their half of the word
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_req_o != '0 |-> result_req_o == ~result_acked)
    else flag_mismatch("result lane requests");

  // a and b leave together, v0 with them only when masked
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cur_op != MASKU_OP_MASK |->
      (operand_b_ready_o == '0 || operand_b_ready_o == '1) &&
      operand_a_ready_o == operand_b_ready_o &&
      operand_m_ready_o == (cur_vm ? '0 : operand_b_ready_o))
    else flag_mismatch("operand readies for logic or vcpop");

  // Mask beats read v0 alone and release it on all lanes at once
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cur_op == MASKU_OP_MASK |->
      operand_a_ready_o == '0 && operand_b_ready_o == '0 &&
      (operand_m_ready_o == '0 || operand_m_ready_o == '1))
    else flag_mismatch("operand readies for mask");

  assert property (@(posedge clk_i) disable iff (!rst_ni) done_o |=> !done_o)
    else flag_mismatch("done longer than one cycle");

  // Busy from acceptance on
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && req_ready_o |=> !req_ready_o)
    else flag_mismatch("request ready right after acceptance");

  // Ready comes back only together with done
  assert property (@(posedge clk_i) disable iff (!rst_ni) $rose(req_ready_o) |-> done_o)
    else flag_mismatch("request ready without done");

  for (genvar l = 0; l < NrLanes; l++) begin : g_lane
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o[l] |-> result_wdata_o[l] == exp_word[l*ElenW +: ElenW] &&
      result_be_o[l] == '1 && result_addr_o[l] == cur_vd && result_id_o[l] == cur_id)
      else flag_mismatch($sformatf("result payload lane %0d", l));

    assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o[l] && !result_gnt_i[l] |=> result_req_o[l] && $stable(result_wdata_o[l]))
      else flag_mismatch($sformatf("result not held lane %0d", l));

    // Active lanes show the head beat until acknowledged
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      mask_valid_o != '0 |->
        mask_valid_o[l] == (lane_active(beats_seen, l) && !mask_acked[l]) &&
        (!mask_valid_o[l] || mask_o[l] == expect_strobe(beats_seen, l)))
      else flag_mismatch($sformatf("mask strobes lane %0d beat %0d", l, beats_seen));

    assert property (@(posedge clk_i) disable iff (!rst_ni)
      mask_valid_o[l] && !mask_ready_i[l] |=> mask_valid_o[l] && $stable(mask_o[l]))
      else flag_mismatch($sformatf("mask not held lane %0d", l));
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic finish_test(string name);
    assert (done_count == issued) else flag_mismatch("done pulses differ from instructions");
    tests++;
    $display("test %s: %0d mismatches", name, errors - mark);
    mark = errors;
  endtask

  initial begin
    rst_ni            = 1'b1;
    req_valid_i       = 1'b0;
    req_op_i          = MASKU_OP_LOGIC;
    req_vm_i          = 1'b1;
    req_sew_i         = SEW8;
    req_vl_i          = '0;
    req_id_i          = '0;
    req_vd_i          = '0;
    operand_a_i       = '0;
    operand_b_i       = '0;
    operand_m_i       = '0;
    operand_a_valid_i = '0;
    operand_b_valid_i = '0;
    operand_m_valid_i = '0;
    result_gnt_i      = '1;
    mask_ready_i      = '1;
    mark              = 0;
    #1 rst_ni = 1'b0;
    repeat (8) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    finish_test("reset");

    // Unmasked on odd instructions
    for (int i = 0; i < 8; i++) begin
      run_insn(MASKU_OP_LOGIC, i[0], SEW8, VlW'($unsigned($random(seed)) % (VrfW + 1)));
    end
    finish_test("logic");

    for (int i = 0; i < 8; i++) begin
      run_insn(MASKU_OP_VCPOP, i[0], SEW8, VlW'($unsigned($random(seed)) % (VrfW + 1)));
    end
    finish_test("vcpop");

    for (int w = 0; w < 4; w++) begin
      repeat (2) run_insn(MASKU_OP_MASK, 1'b0, sew_e'(w),
                          VlW'($unsigned($random(seed)) % (VrfW + 1)));
    end
    finish_test("mask");

    // Random grant and ready stretches
    throttle = 1'b1;
    for (int i = 0; i < 8; i++) begin
      run_insn(MASKU_OP_LOGIC, i[0], SEW8, VlW'($unsigned($random(seed)) % (VrfW + 1)));
      run_insn(MASKU_OP_MASK, 1'b0, sew_e'(i % 4),
               VlW'($unsigned($random(seed)) % (VrfW + 1)));
    end
    throttle = 1'b0;
    finish_test("backpressure");

    $display("%0d tests, %0d instructions, %0d mismatches", tests, issued, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+bench
verilog/masku_pkg.sv
verilog/masku_insn_ctrl.sv
verilog/masku_alu.sv
verilog/masku_mask_queue.sv
verilog/masku_result_queue.sv
verilog/masku.sv
bench/masku_tb.sv

//--- verilog/masku.sv
`default_nettype none

module masku import masku_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Request
  input  logic                          req_valid_i,
  input  masku_op_e                     req_op_i,
  input  logic                          req_vm_i,
  input  sew_e                          req_sew_i,
  input  logic [VlW-1:0]                req_vl_i,
  input  logic [IdW-1:0]                req_id_i,
  input  logic [VdW-1:0]                req_vd_i,
  output logic                          req_ready_o,
  // Operands from the lanes
  input  logic [NrLanes-1:0][ElenW-1:0] operand_a_i,
  input  logic [NrLanes-1:0]            operand_a_valid_i,
  output logic [NrLanes-1:0]            operand_a_ready_o,
  input  logic [NrLanes-1:0][ElenW-1:0] operand_b_i,
  input  logic [NrLanes-1:0]            operand_b_valid_i,
  output logic [NrLanes-1:0]            operand_b_ready_o,
  input  logic [NrLanes-1:0][ElenW-1:0] operand_m_i,
  input  logic [NrLanes-1:0]            operand_m_valid_i,
  output logic [NrLanes-1:0]            operand_m_ready_o,
  // Results to the register file
  output logic [NrLanes-1:0]            result_req_o,
  output logic [NrLanes-1:0][VdW-1:0]   result_addr_o,
  output logic [NrLanes-1:0][IdW-1:0]   result_id_o,
  output logic [NrLanes-1:0][ElenW-1:0] result_wdata_o,
  output logic [NrLanes-1:0][StrbW-1:0] result_be_o,
  input  logic [NrLanes-1:0]            result_gnt_i,
  // Mask strobes to the lanes
  output logic [NrLanes-1:0][StrbW-1:0] mask_o,
  output logic [NrLanes-1:0]            mask_valid_o,
  input  logic [NrLanes-1:0]            mask_ready_i,
  // Response
  output logic                          done_o,
  output logic [IdW-1:0]                done_id_o,
  output logic [VlW-1:0]                popcount_o
);

  masku_op_e       op;
  sew_e            sew;
  logic            vm;
  logic [VlW-1:0]  vl;
  logic [IdW-1:0]  id;
  logic [VdW-1:0]  vd;
  logic [VlW-1:0]  beat_base;
  logic [VrfW-1:0] alu_result;
  logic [VlW-1:0]  alu_popcount;
  logic            rq_push;
  logic            rq_full;
  logic            rq_empty;
  logic            mq_push;
  logic            mq_full;
  logic            mq_empty;

  masku_insn_ctrl ctrl_inst (
    .clk_i, .rst_ni,
    .req_valid_i, .req_op_i, .req_vm_i, .req_sew_i, .req_vl_i, .req_id_i, .req_vd_i,
    .req_ready_o,
    .operand_a_valid_i, .operand_b_valid_i, .operand_m_valid_i,
    .operand_a_ready_o, .operand_b_ready_o, .operand_m_ready_o,
    .rq_full_i   (rq_full),
    .rq_empty_i  (rq_empty),
    .mq_full_i   (mq_full),
    .mq_empty_i  (mq_empty),
    .rq_push_o   (rq_push),
    .mq_push_o   (mq_push),
    .op_o        (op),
    .vm_o        (vm),
    .sew_o       (sew),
    .vl_o        (vl),
    .id_o        (id),
    .vd_o        (vd),
    .beat_base_o (beat_base),
    .popcount_i  (alu_popcount),
    .done_o, .done_id_o, .popcount_o
  );

  // Combinational, works on the live operands
  masku_alu alu_inst (
    .op_i        (op),
    .vm_i        (vm),
    .vl_i        (vl),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .operand_m_i (operand_m_i),
    .result_o    (alu_result),
    .popcount_o  (alu_popcount)
  );

  masku_mask_queue mask_queue_inst (
    .clk_i, .rst_ni,
    .push_i      (mq_push),
    .sew_i       (sew),
    .vl_i        (vl),
    .beat_base_i (beat_base),
    .operand_m_i (operand_m_i),
    .full_o      (mq_full),
    .empty_o     (mq_empty),
    .mask_o, .mask_valid_o, .mask_ready_i
  );

  masku_result_queue result_queue_inst (
    .clk_i, .rst_ni,
    .push_i  (rq_push),
    .wdata_i (alu_result),
    .vd_i    (vd),
    .id_i    (id),
    .full_o  (rq_full),
    .empty_o (rq_empty),
    .result_req_o, .result_addr_o, .result_id_o, .result_wdata_o, .result_be_o,
    .result_gnt_i
  );

endmodule

`default_nettype wire

//--- verilog/masku_alu.sv
`default_nettype none

module masku_alu import masku_pkg::*; (
  input  masku_op_e       op_i,
  input  logic            vm_i,
  input  logic [VlW-1:0]  vl_i,
  input  logic [VrfW-1:0] operand_a_i,
  input  logic [VrfW-1:0] operand_b_i,
  input  logic [VrfW-1:0] operand_m_i,
  output logic [VrfW-1:0] result_o,
  output logic [VlW-1:0]  popcount_o
);

  logic [VrfW-1:0] bit_enable;
  logic [VrfW-1:0] count_word;

  ////////////////////////////////////////
  // Bit enable
  ////////////////////////////////////////

  always_comb begin
    // Body elements below vl
    for (int i = 0; i < VrfW; i++) begin
      bit_enable[i] = (i < vl_i);
    end
    // Inactive elements dropped by v0
    if (!vm_i) bit_enable = bit_enable & operand_m_i;
  end

  ////////////////////////////////////////
  // Merge and count
  ////////////////////////////////////////

  // Enabled bits from the lane result, the rest keep the old vd
  assign result_o = (op_i == MASKU_OP_LOGIC) ?
                    ((operand_a_i & bit_enable) | (operand_b_i & ~bit_enable)) :
                    operand_b_i;

  // Only VCPOP feeds the counter
  assign count_word = (op_i == MASKU_OP_VCPOP) ? (operand_b_i & bit_enable) : '0;

  always_comb begin
    popcount_o = '0;
    for (int i = 0; i < VrfW; i++) begin
      popcount_o = popcount_o + VlW'(count_word[i]);
    end
  end

endmodule

`default_nettype wire

//--- verilog/masku_insn_ctrl.sv
`default_nettype none

module masku_insn_ctrl import masku_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Request from the sequencer
  input  logic                    req_valid_i,
  input  masku_op_e               req_op_i,
  input  logic                    req_vm_i,
  input  sew_e                    req_sew_i,
  input  logic [VlW-1:0]          req_vl_i,
  input  logic [IdW-1:0]          req_id_i,
  input  logic [VdW-1:0]          req_vd_i,
  output logic                    req_ready_o,
  // Operand handshakes
  input  logic [NrLanes-1:0]      operand_a_valid_i,
  input  logic [NrLanes-1:0]      operand_b_valid_i,
  input  logic [NrLanes-1:0]      operand_m_valid_i,
  output logic [NrLanes-1:0]      operand_a_ready_o,
  output logic [NrLanes-1:0]      operand_b_ready_o,
  output logic [NrLanes-1:0]      operand_m_ready_o,
  // Queue status and pushes
  input  logic                    rq_full_i,
  input  logic                    rq_empty_i,
  input  logic                    mq_full_i,
  input  logic                    mq_empty_i,
  output logic                    rq_push_o,
  output logic                    mq_push_o,
  // Held instruction
  output masku_op_e               op_o,
  output logic                    vm_o,
  output sew_e                    sew_o,
  output logic [VlW-1:0]          vl_o,
  output logic [IdW-1:0]          id_o,
  output logic [VdW-1:0]          vd_o,
  output logic [VlW-1:0]          beat_base_o,
  // Response
  input  logic [VlW-1:0]          popcount_i,
  output logic                    done_o,
  output logic [IdW-1:0]          done_id_o,
  output logic [VlW-1:0]          popcount_o
);

  logic           busy_q;
  // Beats still to issue, one for LOGIC and VCPOP
  logic [VlW-1:0] beats_q;
  logic [VlW-1:0] req_beats;
  logic [VlW-1:0] beat_elems;
  logic           accept;
  logic           consume;
  logic           finish;
  logic           ops_valid;

  assign req_ready_o = !busy_q;
  assign accept      = req_valid_i && req_ready_o;

  // Elements covered by one mask beat, and beats for a new request
  assign beat_elems = VlW'(VrfB >> sew_o);
  assign req_beats  = VlW'((req_vl_i + VlW'(VrfB >> req_sew_i) - 1) >>
                      ($clog2(VrfB) - req_sew_i));

  // a and b always, v0 only when masked
  assign ops_valid = (&operand_a_valid_i) && (&operand_b_valid_i) &&
                     (vm_o || (&operand_m_valid_i));

  ////////////////////////////////////////
  // Issue
  ////////////////////////////////////////

  always_comb begin
    operand_a_ready_o = '0;
    operand_b_ready_o = '0;
    operand_m_ready_o = '0;
    rq_push_o         = 1'b0;
    mq_push_o         = 1'b0;
    consume           = 1'b0;
    if (busy_q && beats_q != '0) begin
      case (op_o)
        MASKU_OP_LOGIC, MASKU_OP_VCPOP: begin
          // Single beat, consumes all operands at once
          if (ops_valid && !rq_full_i) begin
            operand_a_ready_o = '1;
            operand_b_ready_o = '1;
            operand_m_ready_o = {NrLanes{!vm_o}};
            rq_push_o         = (op_o == MASKU_OP_LOGIC);
            consume           = 1'b1;
          end
        end
        default: begin
          // One mask beat per cycle, v0 released with the last one
          if ((&operand_m_valid_i) && !mq_full_i) begin
            mq_push_o = 1'b1;
            consume   = 1'b1;
            if (beats_q == VlW'(1)) operand_m_ready_o = '1;
          end
        end
      endcase
    end
    // VCPOP ends on consumption, the others once both queues have drained
    finish = busy_q && ((consume && op_o == MASKU_OP_VCPOP) ||
             (op_o != MASKU_OP_VCPOP && beats_q == '0 && rq_empty_i && mq_empty_i));
  end

  ////////////////////////////////////////
  // State
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      beats_q     <= '0;
      beat_base_o <= '0;
      op_o        <= MASKU_OP_LOGIC;
      vm_o        <= 1'b1;
      sew_o       <= SEW8;
      vl_o        <= '0;
      id_o        <= '0;
      vd_o        <= '0;
      done_o      <= 1'b0;
      done_id_o   <= '0;
      popcount_o  <= '0;
    end else begin
      if (accept) begin
        busy_q      <= 1'b1;
        op_o        <= req_op_i;
        vm_o        <= req_vm_i;
        sew_o       <= req_sew_i;
        vl_o        <= req_vl_i;
        id_o        <= req_id_i;
        vd_o        <= req_vd_i;
        beat_base_o <= '0;
        beats_q     <= (req_op_i == MASKU_OP_MASK) ? req_beats : VlW'(1);
      end else if (consume) begin
        beats_q     <= beats_q - VlW'(1);
        beat_base_o <= beat_base_o + beat_elems;
      end
      if (finish) busy_q <= 1'b0;
      // One-cycle done pulse with id and count
      done_o <= finish;
      if (finish) done_id_o <= id_o;
      if (consume && op_o == MASKU_OP_VCPOP) popcount_o <= popcount_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/masku_mask_queue.sv
`default_nettype none

module masku_mask_queue import masku_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Beat to store
  input  logic                          push_i,
  input  sew_e                          sew_i,
  input  logic [VlW-1:0]                vl_i,
  input  logic [VlW-1:0]                beat_base_i,
  input  logic [VrfW-1:0]               operand_m_i,
  output logic                          full_o,
  output logic                          empty_o,
  // Strobes to the lanes
  output logic [NrLanes-1:0][StrbW-1:0] mask_o,
  output logic [NrLanes-1:0]            mask_valid_o,
  input  logic [NrLanes-1:0]            mask_ready_i
);

  logic [QueueDepth-1:0][NrLanes-1:0][StrbW-1:0] strb_q;
  logic [QueueDepth-1:0][NrLanes-1:0]            valid_q;
  logic [PtrW-1:0]                               wr_ptr_q;
  logic [PtrW-1:0]                               rd_ptr_q;
  logic [CntW-1:0]                               cnt_q;
  logic [NrLanes-1:0][StrbW-1:0]                 beat_strb;
  logic [NrLanes-1:0]                            beat_valid;
  logic                                          retire;

  ////////////////////////////////////////
  // Beat expansion
  ////////////////////////////////////////

  // Element e sits in lane e mod 2, slot e div 2 of the beat
  always_comb begin
    int elem;
    for (int l = 0; l < NrLanes; l++) begin
      for (int b = 0; b < StrbW; b++) begin
        // All bytes of one slot share the element
        elem = int'(beat_base_i) + NrLanes * (b >> sew_i) + l;
        beat_strb[l][b] = (elem < int'(vl_i)) ? operand_m_i[elem] : 1'b0;
      end
      // Lane idle when its first element is past vl
      beat_valid[l] = (int'(beat_base_i) + l) < int'(vl_i);
    end
  end

  ////////////////////////////////////////
  // Queue
  ////////////////////////////////////////

  // Head retires once no lane still waits for its ready
  assign retire = (cnt_q != '0) && ((valid_q[rd_ptr_q] & ~mask_ready_i) == '0);

  assign full_o = (cnt_q == CntW'(QueueDepth));
  // Also empty when the last entry leaves in this cycle
  assign empty_o = (cnt_q == '0) || (cnt_q == CntW'(1) && retire);

  assign mask_o       = strb_q[rd_ptr_q];
  assign mask_valid_o = valid_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) strb_q[wr_ptr_q] <= beat_strb;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Lanes drop their valid on ready
      valid_q[rd_ptr_q] <= valid_q[rd_ptr_q] & ~mask_ready_i;
      if (push_i) begin
        valid_q[wr_ptr_q] <= beat_valid;
        wr_ptr_q          <= wr_ptr_q + 1'b1;
      end
      if (retire) rd_ptr_q <= rd_ptr_q + 1'b1;
      cnt_q <= cnt_q + CntW'(push_i) - CntW'(retire);
    end
  end

endmodule

`default_nettype wire

//--- verilog/masku_pkg.sv
`default_nettype none

package masku_pkg;

  ////////////////////////////////////////
  // Lane geometry
  ////////////////////////////////////////

  localparam int unsigned NrLanes = 2;
  // Lane datapath and its byte strobes
  localparam int unsigned ElenW   = 64;
  localparam int unsigned StrbW   = ElenW / 8;
  // One register-file word spans all lanes
  localparam int unsigned VrfW    = NrLanes * ElenW;
  // Bytes per register-file word, also the SEW8 elements of one mask beat
  localparam int unsigned VrfB    = NrLanes * StrbW;

  ////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////

  // Holds 0 to VrfW
  localparam int unsigned VlW = 8;
  localparam int unsigned IdW = 3;
  localparam int unsigned VdW = 5;

  // Queue depth, power of two so the pointers wrap by themselves
  localparam int unsigned QueueDepth = 2;
  localparam int unsigned PtrW       = $clog2(QueueDepth);
  localparam int unsigned CntW       = $clog2(QueueDepth + 1);

  // Mask unit operations
  typedef enum logic [1:0] {
    MASKU_OP_LOGIC,
    MASKU_OP_VCPOP,
    MASKU_OP_MASK
  } masku_op_e;

  // Element width, value is log2 of the byte size
  typedef enum logic [1:0] {
    SEW8,
    SEW16,
    SEW32,
    SEW64
  } sew_e;

endpackage

`default_nettype wire

//--- verilog/masku_result_queue.sv
`default_nettype none

module masku_result_queue import masku_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Entry from the ALU
  input  logic                          push_i,
  input  logic [VrfW-1:0]               wdata_i,
  input  logic [VdW-1:0]                vd_i,
  input  logic [IdW-1:0]                id_i,
  output logic                          full_o,
  output logic                          empty_o,
  // Register-file write port, per lane
  output logic [NrLanes-1:0]            result_req_o,
  output logic [NrLanes-1:0][VdW-1:0]   result_addr_o,
  output logic [NrLanes-1:0][IdW-1:0]   result_id_o,
  output logic [NrLanes-1:0][ElenW-1:0] result_wdata_o,
  output logic [NrLanes-1:0][StrbW-1:0] result_be_o,
  input  logic [NrLanes-1:0]            result_gnt_i
);

  logic [QueueDepth-1:0][NrLanes-1:0][ElenW-1:0] wdata_q;
  logic [QueueDepth-1:0][VdW-1:0]                addr_q;
  logic [QueueDepth-1:0][IdW-1:0]                id_q;
  logic [QueueDepth-1:0][NrLanes-1:0]            req_q;
  logic [PtrW-1:0]                               wr_ptr_q;
  logic [PtrW-1:0]                               rd_ptr_q;
  logic [CntW-1:0]                               cnt_q;
  logic                                          retire;

  // Head retires once every lane has been granted
  assign retire = (cnt_q != '0) && ((req_q[rd_ptr_q] & ~result_gnt_i) == '0);

  assign full_o = (cnt_q == CntW'(QueueDepth));
  // Look ahead so completion follows the last grant by one cycle
  assign empty_o = (cnt_q == '0) || (cnt_q == CntW'(1) && retire);

  ////////////////////////////////////////
  // Head to the register file
  ////////////////////////////////////////

  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      result_req_o[l]   = req_q[rd_ptr_q][l];
      result_addr_o[l]  = addr_q[rd_ptr_q];
      result_id_o[l]    = id_q[rd_ptr_q];
      result_wdata_o[l] = wdata_q[rd_ptr_q][l];
      // Whole words, every byte written
      result_be_o[l]    = '1;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      wdata_q[wr_ptr_q] <= wdata_i;
      addr_q[wr_ptr_q]  <= vd_i;
      id_q[wr_ptr_q]    <= id_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Granted lanes stop requesting
      req_q[rd_ptr_q] <= req_q[rd_ptr_q] & ~result_gnt_i;
      if (push_i) begin
        req_q[wr_ptr_q] <= '1;
        wr_ptr_q        <= wr_ptr_q + 1'b1;
      end
      if (retire) rd_ptr_q <= rd_ptr_q + 1'b1;
      cnt_q <= cnt_q + CntW'(push_i) - CntW'(retire);
    end
  end

endmodule

`default_nettype wire
